// ==== filelist.f ====
rtl/axi_pkg.sv
rtl/cache_pkg.sv
rtl/icache.sv
rtl/uncached_data_ctrl.sv
rtl/axi_read_arbiter.sv
rtl/axi_write_unit.sv
rtl/mem_subsystem.sv
tb/axi_slave_model.sv
tb/tb_mem_subsystem.sv

// ==== Makefile ====
SIM      := verilator
FLAGS    := --binary --timing --assert -j 0
TOP      := tb_mem_subsystem
FILELIST := filelist.f
OBJ_DIR  := obj_dir
LOG      := sim.log

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)

run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@if grep -qF '*** TEST FAILED ***' $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -qF '*** TEST PASSED ***' $(LOG) || { echo "no result in $(LOG)"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== tb/tb_mem_subsystem.sv ====
`timescale 1ns/1ns

module tb_mem_subsystem;
    import axi_pkg::*;

    localparam int CLK_PERIOD   = 20;
    localparam int NUM_ACCESSES = 56;
    localparam int MAX_WAIT     = 1000;   // cycles per access

    logic       aclk;
    logic       reset;
    logic       rand_en;
    logic       inst_valid;
    axi_addr_t  inst_addr;
    logic       inst_busy;
    logic       inst_ok;
    axi_data_t  inst_rdata;
    logic       data_valid;
    logic       data_op;
    axi_addr_t  data_addr;
    axi_strb_t  data_wstrb;
    axi_data_t  data_wdata;
    logic       data_busy;
    logic       data_ok;
    axi_data_t  data_rdata;
    axi_id_t    arid, rid, awid, bid;
    axi_addr_t  araddr, awaddr;
    axi_len_t   arlen, awlen;
    axi_data_t  rdata, wdata;
    axi_strb_t  wstrb;
    logic [2:0] arsize, arprot, awsize, awprot;
    logic [1:0] arburst, arlock, awburst, awlock, rresp, bresp;
    logic [3:0] arcache, awcache;
    logic       arvalid, arready, rlast, rvalid, rready;
    logic       awvalid, awready, wlast, wvalid, wready, bvalid, bready;

    int        errors [6];
    int        cur_test;
    int        total;
    axi_data_t exp_mem [axi_addr_t];   // expected effect of stores

    axi_id_t   ar_ids [$];
    axi_addr_t ar_addrs [$];
    axi_len_t  ar_lens [$];
    axi_addr_t aw_addrs [$];
    axi_len_t  aw_lens [$];
    axi_strb_t w_strbs [$];

    mem_subsystem dut_i (.*);
    axi_slave_model slave_i (.*);

    always #(CLK_PERIOD / 2) aclk = ~aclk;

    always @(posedge aclk) begin
        if (arvalid && arready) begin
            ar_ids.push_back(arid);
            ar_addrs.push_back(araddr);
            ar_lens.push_back(arlen);
        end
        if (awvalid && awready) begin
            aw_addrs.push_back(awaddr);
            aw_lens.push_back(awlen);
        end
        if (wvalid && wready) w_strbs.push_back(wstrb);
    end

    function automatic axi_data_t mem_word(axi_addr_t a);
        axi_addr_t w;
        w = {a[31:2], 2'b00};
        return exp_mem.exists(w) ? exp_mem[w] : (w ^ 32'h5a5a_0000);
    endfunction

    function automatic axi_data_t merge_bytes(axi_data_t old, axi_data_t d, axi_strb_t s);
        axi_data_t r;
        r = old;
        for (int b = 0; b < 4; b++) begin
            if (s[b]) r[8*b +: 8] = d[8*b +: 8];
        end
        return r;
    endfunction

    task automatic report_error(input string msg);
        $display("ERROR at %0t: %s", $time, msg);
        errors[cur_test]++;
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("FAIL %0t %s got %b expected %b", $time, name, got, exp);
            errors[cur_test]++;
        end
    endtask

    task automatic check_data(input string name, input axi_data_t got, input axi_data_t exp);
        if (got !== exp) begin
            $display("FAIL %0t %s got %h expected %h", $time, name, got, exp);
            errors[cur_test]++;
        end
    endtask

    task automatic check_addr(input string name, input axi_addr_t got, input axi_addr_t exp);
        if (got !== exp) begin
            $display("FAIL %0t %s got %h expected %h", $time, name, got, exp);
            errors[cur_test]++;
        end
    endtask

    task automatic check_id(input string name, input axi_id_t got, input axi_id_t exp);
        if (got !== exp) begin
            $display("FAIL %0t %s got %0d expected %0d", $time, name, got, exp);
            errors[cur_test]++;
        end
    endtask

    task automatic check_len(input string name, input axi_len_t got, input axi_len_t exp);
        if (got !== exp) begin
            $display("FAIL %0t %s got %0d expected %0d", $time, name, got, exp);
            errors[cur_test]++;
        end
    endtask

    task automatic check_strb(input string name, input axi_strb_t got, input axi_strb_t exp);
        if (got !== exp) begin
            $display("FAIL %0t %s got %b expected %b", $time, name, got, exp);
            errors[cur_test]++;
        end
    endtask

    task automatic check_field(input string name, input logic [3:0] got, input logic [3:0] exp);
        if (got !== exp) begin
            $display("FAIL %0t %s got %b expected %b", $time, name, got, exp);
            errors[cur_test]++;
        end
    endtask

    // word-sized INCR transfers, normal unprotected access
    task automatic fixed_fields();
        check_field("arsize", {1'b0, arsize}, 4'd2);
        check_field("arburst", {2'b00, arburst}, 4'd1);
        check_field("arlock", {2'b00, arlock}, 4'd0);
        check_field("arcache", arcache, 4'd0);
        check_field("arprot", {1'b0, arprot}, 4'd0);
        check_id("awid", awid, AXI_ID_DATA);
        check_field("awsize", {1'b0, awsize}, 4'd2);
        check_field("awburst", {2'b00, awburst}, 4'd1);
        check_field("awlock", {2'b00, awlock}, 4'd0);
        check_field("awcache", awcache, 4'd0);
        check_field("awprot", {1'b0, awprot}, 4'd0);
        check_bit("wlast", wlast, 1'b1);
    endtask

    task automatic clear_logs();
        ar_ids.delete();
        ar_addrs.delete();
        ar_lens.delete();
        aw_addrs.delete();
        aw_lens.delete();
        w_strbs.delete();
    endtask

    // called on a falling edge, returns on the falling edge that shows inst_ok
    task automatic fetch(input axi_addr_t addr, output axi_data_t rd, output int cycles);
        int n;
        while (inst_busy) @(negedge aclk);
        inst_valid = 1'b1;
        inst_addr  = addr;
        @(negedge aclk);
        inst_valid = 1'b0;
        n = 1;
        while (!inst_ok && n < MAX_WAIT) begin
            @(negedge aclk);
            n++;
        end
        if (!inst_ok) report_error($sformatf("fetch at %h never returned inst_ok", addr));
        rd     = inst_rdata;
        cycles = n;
    endtask

    task automatic data_access(input logic op, input axi_addr_t addr, input axi_strb_t strb,
                               input axi_data_t wd, output axi_data_t rd);
        int n;
        while (data_busy) @(negedge aclk);
        if (op) exp_mem[{addr[31:2], 2'b00}] = merge_bytes(mem_word(addr), wd, strb);
        data_valid = 1'b1;
        data_op    = op;
        data_addr  = addr;
        data_wstrb = strb;
        data_wdata = wd;
        @(negedge aclk);
        data_valid = 1'b0;
        n = 1;
        while (!data_ok && n < MAX_WAIT) begin
            @(negedge aclk);
            n++;
        end
        if (!data_ok) report_error($sformatf("access at %h never returned data_ok", addr));
        rd = data_rdata;
    endtask

    task automatic reset_levels();
        cur_test = 0;
        check_bit("arvalid", arvalid, 1'b0);
        check_bit("awvalid", awvalid, 1'b0);
        check_bit("wvalid", wvalid, 1'b0);
        check_bit("rready", rready, 1'b0);
        check_bit("bready", bready, 1'b0);
        check_bit("inst_busy", inst_busy, 1'b0);
        check_bit("data_busy", data_busy, 1'b0);
        check_bit("inst_ok", inst_ok, 1'b0);
        check_bit("data_ok", data_ok, 1'b0);
    endtask

    task automatic miss_then_hit();
        axi_data_t rd;
        int        n;
        cur_test = 1;
        clear_logs();
        fetch(32'h0000_1004, rd, n);
        check_data("inst_rdata", rd, mem_word(32'h0000_1004));
        if (ar_ids.size() != 1) begin
            report_error($sformatf("miss issued %0d read bursts instead of one", ar_ids.size()));
        end else begin
            check_id("arid", ar_ids[0], AXI_ID_INST);
            check_len("arlen", ar_lens[0], 4'd3);
            check_addr("araddr", ar_addrs[0], 32'h0000_1000);
        end
        fetch(32'h0000_100c, rd, n);
        check_data("inst_rdata", rd, mem_word(32'h0000_100c));
        if (n != 1) report_error($sformatf("hit answered after %0d cycles, not 1", n));
        if (ar_ids.size() != 1) report_error("a hit in a filled line started a read burst");
    endtask

    task automatic index_conflict();
        axi_data_t rd;
        int        n;
        cur_test = 2;
        clear_logs();
        fetch(32'h0000_2008, rd, n);   // same index with a new tag
        check_data("inst_rdata", rd, mem_word(32'h0000_2008));
        fetch(32'h0000_1000, rd, n);
        check_data("inst_rdata", rd, mem_word(32'h0000_1000));
        if (ar_addrs.size() != 2) begin
            report_error($sformatf("expected two refills, saw %0d", ar_addrs.size()));
        end else begin
            check_addr("araddr", ar_addrs[0], 32'h0000_2000);
            check_addr("araddr", ar_addrs[1], 32'h0000_1000);
        end
    endtask

    task automatic store_then_load();
        axi_data_t rd;
        cur_test = 3;
        clear_logs();
        data_access(1'b1, 32'h8000_0040, 4'b0110, 32'haabb_ccdd, rd);
        if (aw_addrs.size() != 1 || w_strbs.size() != 1) begin
            report_error("store did not give exactly one write address and one data beat");
        end else begin
            check_addr("awaddr", aw_addrs[0], 32'h8000_0040);
            check_len("awlen", aw_lens[0], 4'd0);
            check_strb("wstrb", w_strbs[0], 4'b0110);
        end
        data_access(1'b0, 32'h8000_0040, 4'h0, 32'h0, rd);
        check_data("data_rdata", rd,
                   merge_bytes(32'h8000_0040 ^ 32'h5a5a_0000, 32'haabb_ccdd, 4'b0110));
        if (ar_ids.size() != 1) begin
            report_error("uncached load did not give exactly one read burst");
        end else begin
            check_id("arid", ar_ids[0], AXI_ID_DATA);
            check_len("arlen", ar_lens[0], 4'd0);
        end
        fixed_fields();
    endtask

    task automatic same_cycle_tie();
        axi_data_t ird;
        axi_data_t drd;
        int        n;
        cur_test = 4;
        clear_logs();
        fork
            fetch(32'h0000_3010, ird, n);
            begin
                @(negedge aclk);   // refill_req and rd_req then reach the arbiter together
                data_access(1'b0, 32'h8000_0100, 4'h0, 32'h0, drd);
            end
        join
        check_data("inst_rdata", ird, mem_word(32'h0000_3010));
        check_data("data_rdata", drd, mem_word(32'h8000_0100));
        if (ar_ids.size() != 2) begin
            report_error($sformatf("expected two read bursts, saw %0d", ar_ids.size()));
        end else begin
            check_id("arid", ar_ids[0], AXI_ID_DATA);   // uncached read goes first
            check_id("arid", ar_ids[1], AXI_ID_INST);
        end
    endtask

    task automatic random_mix();
        axi_data_t ird;
        axi_data_t drd;
        axi_addr_t fa;
        axi_addr_t da;
        int        n;
        cur_test = 5;
        rand_en  = 1'b1;
        for (int i = 0; i < 24; i++) begin
            fa = 32'h0000_4000 + ((i * 356) & 32'h1ffc);   // spans two index wraps
            da = 32'h8000_0200 + 4 * (i % 8);
            fork
                fetch(fa, ird, n);
                data_access(i % 3 == 0, da, axi_strb_t'(i % 15 + 1), 32'hc0de_0000 + i, drd);
            join
            check_data("inst_rdata", ird, mem_word(fa));
            if (i % 3 != 0) check_data("data_rdata", drd, mem_word(da));
        end
        rand_en = 1'b0;
    endtask

    initial begin
        aclk       = 1'b0;
        reset      = 1'b1;
        rand_en    = 1'b0;
        inst_valid = 1'b0;
        inst_addr  = '0;
        data_valid = 1'b0;
        data_op    = 1'b0;
        data_addr  = '0;
        data_wstrb = '0;
        data_wdata = '0;
        cur_test   = 0;
        repeat (3) @(posedge aclk);
        @(negedge aclk);
        reset = 1'b0;
        reset_levels();
        miss_then_hit();
        index_conflict();
        store_then_load();
        same_cycle_tie();
        random_mix();
        total = errors[0] + errors[1] + errors[2] + errors[3] + errors[4] + errors[5];
        $display("errors: reset %0d hit %0d conflict %0d store %0d tie %0d random %0d total %0d",
                 errors[0], errors[1], errors[2], errors[3], errors[4], errors[5], total);
        if (total == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

    // ends a hung run
    initial begin
        #(CLK_PERIOD * (NUM_ACCESSES * 200 + 100));
        $display("ERROR: watchdog expired before the tests finished");
        $display("*** TEST FAILED ***");
        $finish;
    end

endmodule

// ==== tb/axi_slave_model.sv ====
`timescale 1ns/1ns

module axi_slave_model (
    input  logic               aclk,
    input  logic               reset,
    input  logic               rand_en,
    input  axi_pkg::axi_id_t   arid,
    input  axi_pkg::axi_addr_t araddr,
    input  axi_pkg::axi_len_t  arlen,
    input  logic               arvalid,
    output logic               arready,
    output axi_pkg::axi_id_t   rid,
    output axi_pkg::axi_data_t rdata,
    output logic [1:0]         rresp,
    output logic               rlast,
    output logic               rvalid,
    input  logic               rready,
    input  axi_pkg::axi_addr_t awaddr,
    input  logic               awvalid,
    output logic               awready,
    input  axi_pkg::axi_data_t wdata,
    input  axi_pkg::axi_strb_t wstrb,
    input  logic               wvalid,
    output logic               wready,
    output axi_pkg::axi_id_t   bid,
    output logic [1:0]         bresp,
    output logic               bvalid,
    input  logic               bready
);
    import axi_pkg::*;

    integer seed = 62;

    axi_data_t shadow [axi_addr_t];   // stored words by word address

    logic      ar_fire, r_fire, aw_fire, w_fire, b_fire;
    axi_id_t   ar_id_s, rd_id;
    axi_addr_t ar_addr_s, aw_addr_s, rd_addr;
    axi_len_t  ar_len_s, rd_left;
    axi_data_t w_data_s;
    axi_strb_t w_strb_s;
    logic      rd_active, aw_got, w_got;

    assign rresp = 2'b00;
    assign bresp = 2'b00;
    assign bid   = AXI_ID_DATA;

    function automatic logic ready_now();
        return !rand_en || ({$random(seed)} % 4 == 0);
    endfunction

    function automatic axi_data_t word_at(axi_addr_t a);
        return shadow.exists(a) ? shadow[a] : (a ^ 32'h5a5a_0000);
    endfunction

    task automatic store_word(input axi_addr_t a, input axi_data_t d, input axi_strb_t s);
        axi_data_t w;
        w = word_at(a);
        for (int b = 0; b < 4; b++) begin
            if (s[b]) w[8*b +: 8] = d[8*b +: 8];
        end
        shadow[a] = w;
    endtask

    task automatic clear_outputs();
        arready   = 1'b0;
        rvalid    = 1'b0;
        rlast     = 1'b0;
        rid       = '0;
        rdata     = '0;
        awready   = 1'b0;
        wready    = 1'b0;
        bvalid    = 1'b0;
        rd_active = 1'b0;
        aw_got    = 1'b0;
        w_got     = 1'b0;
    endtask

    initial clear_outputs();

    // handshakes as the DUT sees them at the rising edge
    always @(posedge aclk) begin
        ar_fire <= arvalid && arready;
        r_fire  <= rvalid && rready;
        aw_fire <= awvalid && awready;
        w_fire  <= wvalid && wready;
        b_fire  <= bvalid && bready;
        if (arvalid && arready) begin
            ar_id_s   <= arid;
            ar_addr_s <= araddr;
            ar_len_s  <= arlen;
        end
        if (awvalid && awready) aw_addr_s <= awaddr;
        if (wvalid && wready) begin
            w_data_s <= wdata;
            w_strb_s <= wstrb;
        end
    end

    always @(negedge aclk) begin
        if (reset) begin
            clear_outputs();
        end else begin
            if (ar_fire) begin
                arready   = 1'b0;
                rd_active = 1'b1;
                rd_id     = ar_id_s;
                rd_addr   = {ar_addr_s[31:2], 2'b00};
                rd_left   = ar_len_s;
            end else if (arvalid && !arready && !rd_active) begin
                arready = ready_now();
            end
            if (r_fire) begin
                rvalid = 1'b0;
                if (rlast) begin
                    rd_active = 1'b0;
                end else begin
                    rd_addr = rd_addr + 32'd4;
                    rd_left = rd_left - 4'd1;
                end
            end
            if (rd_active && !rvalid && ready_now()) begin
                rvalid = 1'b1;
                rid    = rd_id;
                rdata  = word_at(rd_addr);
                rlast  = (rd_left == 4'd0);
            end
            // write address and data may come in either order
            if (aw_fire) begin
                awready = 1'b0;
                aw_got  = 1'b1;
            end else if (awvalid && !awready && !aw_got) begin
                awready = ready_now();
            end
            if (w_fire) begin
                wready = 1'b0;
                w_got  = 1'b1;
            end else if (wvalid && !wready && !w_got) begin
                wready = ready_now();
            end
            if (b_fire) bvalid = 1'b0;
            if (aw_got && w_got && !bvalid && ready_now()) begin
                store_word({aw_addr_s[31:2], 2'b00}, w_data_s, w_strb_s);
                aw_got = 1'b0;
                w_got  = 1'b0;
                bvalid = 1'b1;
            end
        end
    end

endmodule

// ==== rtl/mem_subsystem.sv ====
`timescale 1ns/1ns

module mem_subsystem (
    input  logic               aclk,
    input  logic               reset,
    // fetch port
    input  logic               inst_valid,
    input  axi_pkg::axi_addr_t inst_addr,
    output logic               inst_busy,
    output logic               inst_ok,
    output axi_pkg::axi_data_t inst_rdata,
    // data port
    input  logic               data_valid,
    input  logic               data_op,
    input  axi_pkg::axi_addr_t data_addr,
    input  axi_pkg::axi_strb_t data_wstrb,
    input  axi_pkg::axi_data_t data_wdata,
    output logic               data_busy,
    output logic               data_ok,
    output axi_pkg::axi_data_t data_rdata,
    // AXI read
    output axi_pkg::axi_id_t   arid,
    output axi_pkg::axi_addr_t araddr,
    output axi_pkg::axi_len_t  arlen,
    output logic [2:0]         arsize,
    output logic [1:0]         arburst,
    output logic [1:0]         arlock,
    output logic [3:0]         arcache,
    output logic [2:0]         arprot,
    output logic               arvalid,
    input  logic               arready,
    input  axi_pkg::axi_id_t   rid,
    input  axi_pkg::axi_data_t rdata,
    input  logic [1:0]         rresp,
    input  logic               rlast,
    input  logic               rvalid,
    output logic               rready,
    // AXI write
    output axi_pkg::axi_id_t   awid,
    output axi_pkg::axi_addr_t awaddr,
    output axi_pkg::axi_len_t  awlen,
    output logic [2:0]         awsize,
    output logic [1:0]         awburst,
    output logic [1:0]         awlock,
    output logic [3:0]         awcache,
    output logic [2:0]         awprot,
    output logic               awvalid,
    input  logic               awready,
    output axi_pkg::axi_data_t wdata,
    output axi_pkg::axi_strb_t wstrb,
    output logic               wlast,
    output logic               wvalid,
    input  logic               wready,
    input  axi_pkg::axi_id_t   bid,
    input  logic [1:0]         bresp,
    input  logic               bvalid,
    output logic               bready
);
    import axi_pkg::*;
    import cache_pkg::*;

    logic      refill_req;
    axi_addr_t refill_addr;
    logic      refill_done;
    line_t     refill_line;
    logic      rd_req;
    axi_addr_t rd_addr;
    logic      rd_done;
    axi_data_t rd_data;
    logic      wr_req;
    axi_addr_t wr_addr;
    axi_strb_t wr_strb;
    axi_data_t wr_data;
    logic      wr_done;

    // fixed fields, every transfer is word sized
    assign arsize  = AXI_SIZE_WORD;
    assign arburst = AXI_BURST_INCR;
    assign arlock  = AXI_LOCK_NORMAL;
    assign arcache = AXI_CACHE_DEFAULT;
    assign arprot  = AXI_PROT_DEFAULT;
    assign awid    = AXI_ID_DATA;
    assign awlen   = AXI_LEN_SINGLE;
    assign awsize  = AXI_SIZE_WORD;
    assign awburst = AXI_BURST_INCR;
    assign awlock  = AXI_LOCK_NORMAL;
    assign awcache = AXI_CACHE_DEFAULT;
    assign awprot  = AXI_PROT_DEFAULT;
    assign wlast   = 1'b1;   // single beat writes

    icache icache_i (
        .aclk        (aclk),
        .reset       (reset),
        .inst_valid  (inst_valid),
        .inst_addr   (inst_addr),
        .inst_busy   (inst_busy),
        .inst_ok     (inst_ok),
        .inst_rdata  (inst_rdata),
        .refill_req  (refill_req),
        .refill_addr (refill_addr),
        .refill_done (refill_done),
        .refill_line (refill_line)
    );

    uncached_data_ctrl uncached_i (
        .aclk       (aclk),
        .reset      (reset),
        .data_valid (data_valid),
        .data_op    (data_op),
        .data_addr  (data_addr),
        .data_wstrb (data_wstrb),
        .data_wdata (data_wdata),
        .data_busy  (data_busy),
        .data_ok    (data_ok),
        .data_rdata (data_rdata),
        .rd_req     (rd_req),
        .rd_addr    (rd_addr),
        .rd_done    (rd_done),
        .rd_data    (rd_data),
        .wr_req     (wr_req),
        .wr_addr    (wr_addr),
        .wr_strb    (wr_strb),
        .wr_data    (wr_data),
        .wr_done    (wr_done)
    );

    axi_read_arbiter rd_arb_i (
        .aclk        (aclk),
        .reset       (reset),
        .refill_req  (refill_req),
        .refill_addr (refill_addr),
        .refill_done (refill_done),
        .refill_line (refill_line),
        .rd_req      (rd_req),
        .rd_addr     (rd_addr),
        .rd_done     (rd_done),
        .rd_data     (rd_data),
        .arid        (arid),
        .araddr      (araddr),
        .arlen       (arlen),
        .arvalid     (arvalid),
        .arready     (arready),
        .rid         (rid),
        .rdata       (rdata),
        .rlast       (rlast),
        .rvalid      (rvalid),
        .rready      (rready)
    );

    axi_write_unit wr_unit_i (
        .aclk    (aclk),
        .reset   (reset),
        .wr_req  (wr_req),
        .wr_addr (wr_addr),
        .wr_strb (wr_strb),
        .wr_data (wr_data),
        .wr_done (wr_done),
        .awaddr  (awaddr),
        .awvalid (awvalid),
        .awready (awready),
        .wdata   (wdata),
        .wstrb   (wstrb),
        .wvalid  (wvalid),
        .wready  (wready),
        .bvalid  (bvalid),
        .bready  (bready)
    );

endmodule

// ==== rtl/axi_write_unit.sv ====
`timescale 1ns/1ns

module axi_write_unit (
    input  logic               aclk,
    input  logic               reset,
    input  logic               wr_req,
    input  axi_pkg::axi_addr_t wr_addr,
    input  axi_pkg::axi_strb_t wr_strb,
    input  axi_pkg::axi_data_t wr_data,
    output logic               wr_done,
    output axi_pkg::axi_addr_t awaddr,
    output logic               awvalid,
    input  logic               awready,
    output axi_pkg::axi_data_t wdata,
    output axi_pkg::axi_strb_t wstrb,
    output logic               wvalid,
    input  logic               wready,
    input  logic               bvalid,
    output logic               bready
);
    import axi_pkg::*;

    logic active;
    logic start;

    // the controller still holds wr_req in the wr_done cycle
    assign start  = wr_req && !active && !wr_done;
    assign bready = active && !awvalid && !wvalid;

    // payload is held by the requester for the whole transfer
    assign awaddr = wr_addr;
    assign wdata  = wr_data;
    assign wstrb  = wr_strb;

    always_ff @(posedge aclk) begin
        if (reset) begin
            active  <= 1'b0;
            awvalid <= 1'b0;
            wvalid  <= 1'b0;
            wr_done <= 1'b0;
        end else begin
            wr_done <= bready && bvalid;
            if (start) begin
                active  <= 1'b1;
                awvalid <= 1'b1;
                wvalid  <= 1'b1;
            end else begin
                if (awvalid && awready) awvalid <= 1'b0;  // AW and W retire independently
                if (wvalid && wready) wvalid <= 1'b0;
                if (bready && bvalid) active <= 1'b0;
            end
        end
    end

endmodule

// ==== rtl/axi_read_arbiter.sv ====
`timescale 1ns/1ns

module axi_read_arbiter (
    input  logic               aclk,
    input  logic               reset,
    input  logic               refill_req,
    input  axi_pkg::axi_addr_t refill_addr,
    output logic               refill_done,
    output cache_pkg::line_t   refill_line,
    input  logic               rd_req,
    input  axi_pkg::axi_addr_t rd_addr,
    output logic               rd_done,
    output axi_pkg::axi_data_t rd_data,
    output axi_pkg::axi_id_t   arid,
    output axi_pkg::axi_addr_t araddr,
    output axi_pkg::axi_len_t  arlen,
    output logic               arvalid,
    input  logic               arready,
    input  axi_pkg::axi_id_t   rid,
    input  axi_pkg::axi_data_t rdata,
    input  logic               rlast,
    input  logic               rvalid,
    output logic               rready
);
    import axi_pkg::*;
    import cache_pkg::*;

    typedef enum logic [1:0] {IDLE, ADDR, DATA, DONE} state_t;

    state_t    state;
    logic      sel_data;   // uncached read in service
    axi_addr_t addr_q;
    line_t     line_q;
    logic      beat;

    assign arvalid = (state == ADDR);
    assign rready  = (state == DATA);
    assign arid    = sel_data ? AXI_ID_DATA : AXI_ID_INST;
    assign araddr  = addr_q;
    assign arlen   = sel_data ? AXI_LEN_SINGLE : LINE_LEN;

    // only beats of our own burst count
    assign beat = rvalid && rready && (rid == arid);

    assign refill_done = (state == DONE) && !sel_data;
    assign rd_done     = (state == DONE) && sel_data;
    assign refill_line = line_q;
    assign rd_data     = line_q[$bits(line_t)-1 -: $bits(axi_data_t)];  // last beat in

    always_ff @(posedge aclk) begin
        if (reset) begin
            state <= IDLE;
        end else begin
            case (state)
                IDLE:    if (rd_req || refill_req) state <= ADDR;
                ADDR:    if (arready) state <= DATA;
                DATA:    if (beat && rlast) state <= DONE;
                DONE:    state <= IDLE;
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge aclk) begin
        if (state == IDLE) begin
            sel_data <= rd_req;   // uncached read wins a tie
            addr_q   <= rd_req ? rd_addr : refill_addr;
        end
        if (beat) begin
            // shift down so word 0 lands at the bottom after four beats
            line_q <= {rdata, line_q[$bits(line_t)-1:$bits(axi_data_t)]};
        end
    end

    assert property (@(posedge aclk) disable iff (reset)
        arvalid && !arready |=> arvalid && $stable(araddr) && $stable(arlen));

endmodule

// ==== rtl/uncached_data_ctrl.sv ====
`timescale 1ns/1ns

module uncached_data_ctrl (
    input  logic               aclk,
    input  logic               reset,
    input  logic               data_valid,
    input  logic               data_op,
    input  axi_pkg::axi_addr_t data_addr,
    input  axi_pkg::axi_strb_t data_wstrb,
    input  axi_pkg::axi_data_t data_wdata,
    output logic               data_busy,
    output logic               data_ok,
    output axi_pkg::axi_data_t data_rdata,
    output logic               rd_req,
    output axi_pkg::axi_addr_t rd_addr,
    input  logic               rd_done,
    input  axi_pkg::axi_data_t rd_data,
    output logic               wr_req,
    output axi_pkg::axi_addr_t wr_addr,
    output axi_pkg::axi_strb_t wr_strb,
    output axi_pkg::axi_data_t wr_data,
    input  logic               wr_done
);
    import axi_pkg::*;

    logic      pending;
    logic      op_q;    // 1 = store
    axi_addr_t addr_q;
    axi_strb_t strb_q;
    axi_data_t wdata_q;

    assign data_busy = pending || data_ok;
    assign rd_req    = pending && !op_q;
    assign wr_req    = pending && op_q;
    assign rd_addr   = addr_q;
    assign wr_addr   = addr_q;
    assign wr_strb   = strb_q;
    assign wr_data   = wdata_q;

    always_ff @(posedge aclk) begin
        if (reset) begin
            pending <= 1'b0;
            data_ok <= 1'b0;
        end else begin
            data_ok <= (rd_req && rd_done) || (wr_req && wr_done);
            if (!data_busy && data_valid) pending <= 1'b1;
            else if ((rd_req && rd_done) || (wr_req && wr_done)) pending <= 1'b0;
        end
    end

    always_ff @(posedge aclk) begin
        if (!data_busy && data_valid) begin
            op_q    <= data_op;
            addr_q  <= data_addr;
            strb_q  <= data_wstrb;
            wdata_q <= data_wdata;
        end
        if (rd_req && rd_done) data_rdata <= rd_data;
    end

    assert property (@(posedge aclk) disable iff (reset) !(rd_req && wr_req));

endmodule

// ==== rtl/icache.sv ====
`timescale 1ns/1ns

module icache (
    input  logic               aclk,
    input  logic               reset,
    input  logic               inst_valid,
    input  axi_pkg::axi_addr_t inst_addr,
    output logic               inst_busy,
    output logic               inst_ok,
    output axi_pkg::axi_data_t inst_rdata,
    output logic               refill_req,
    output axi_pkg::axi_addr_t refill_addr,
    input  logic               refill_done,
    input  cache_pkg::line_t   refill_line
);
    import axi_pkg::*;
    import cache_pkg::*;

    typedef enum logic [1:0] {IDLE, LOOKUP, REFILL, RESPOND} state_t;

    state_t state;

    logic [NUM_LINES-1:0] valid_bits;
    tag_t                 tag_array [NUM_LINES];
    line_t                data_array [NUM_LINES];

    tag_t      req_tag;
    index_t    req_index;
    offset_t   req_offset;
    word_sel_t word_sel;
    line_t     cur_line;
    logic      hit;

    assign hit = valid_bits[req_index] && (tag_array[req_index] == req_tag);

    // after a refill the array already holds the line, so one read path serves both
    assign cur_line   = data_array[req_index];
    assign word_sel   = req_offset[3:2];
    assign inst_rdata = cur_line[32*word_sel +: 32];

    assign inst_busy   = (state != IDLE);
    assign inst_ok     = (state == LOOKUP && hit) || (state == RESPOND);
    assign refill_req  = (state == REFILL);
    assign refill_addr = {req_tag, req_index, {$bits(offset_t){1'b0}}};

    always_ff @(posedge aclk) begin
        if (reset) begin
            state      <= IDLE;
            valid_bits <= '0;
        end else begin
            case (state)
                IDLE:    if (inst_valid) state <= LOOKUP;
                LOOKUP:  state <= hit ? IDLE : REFILL;
                REFILL: begin
                    if (refill_done) begin
                        valid_bits[req_index] <= 1'b1;
                        state                 <= RESPOND;
                    end
                end
                RESPOND: state <= IDLE;
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge aclk) begin
        if (state == IDLE && inst_valid) begin
            {req_tag, req_index, req_offset} <= inst_addr;
        end
        if (state == REFILL && refill_done) begin
            tag_array[req_index]  <= req_tag;
            data_array[req_index] <= refill_line;
        end
    end

    // the arbiter may take several cycles to pick this refill up
    assert property (@(posedge aclk) disable iff (reset)
        refill_req && $past(refill_req) |-> $stable(refill_addr));

endmodule

// ==== rtl/cache_pkg.sv ====
package cache_pkg;

    // address split: tag | index | offset
    typedef logic [19:0]  tag_t;
    typedef logic [7:0]   index_t;
    typedef logic [3:0]   offset_t;
    typedef logic [127:0] line_t;

    localparam int NUM_LINES      = 256;
    localparam int WORDS_PER_LINE = 4;

    // arlen of a line refill, same width as the AXI len field
    localparam logic [3:0] LINE_LEN = 4'd3;

    typedef logic [$clog2(WORDS_PER_LINE)-1:0] word_sel_t;

endpackage

// ==== rtl/axi_pkg.sv ====
package axi_pkg;

    typedef logic [31:0] axi_addr_t;
    typedef logic [31:0] axi_data_t;
    typedef logic [3:0]  axi_strb_t;
    typedef logic [3:0]  axi_id_t;
    typedef logic [3:0]  axi_len_t;   // beats minus one

    localparam axi_id_t AXI_ID_INST = 4'd0;    // icache refills
    localparam axi_id_t AXI_ID_DATA = 4'd1;    // uncached reads, all writes

    localparam axi_len_t    AXI_LEN_SINGLE    = 4'd0;
    localparam logic [2:0]  AXI_SIZE_WORD     = 3'b010;  // 4 bytes per beat
    localparam logic [1:0]  AXI_BURST_INCR    = 2'b01;
    localparam logic [1:0]  AXI_LOCK_NORMAL   = 2'b00;
    localparam logic [3:0]  AXI_CACHE_DEFAULT = 4'b0000;
    localparam logic [2:0]  AXI_PROT_DEFAULT  = 3'b000;

endpackage
